/* common/tile_pkg.sv */
//////////////////////////////////////////////////
// shared widths, vector types and memory map
// wake-up counter size for delayed reset release
// control register offsets and NoC bridge states
//////////////////////////////////////////////////

`default_nettype none

package tile_pkg;

  // request and NoC widths
  localparam int unsigned AddrWidth    = 64;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned NocFlitWidth = 64;
  localparam int unsigned IrqWidth     = 2;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [NocFlitWidth-1:0] flit_t;
  // mip and sip lines
  typedef logic [IrqWidth-1:0]     irq_t;

  // top bit sets after 32768 cycles, enough for the srams to initialise
  localparam int unsigned WakeUpCntWidth = 16;
  // gated reset, irq lines, ipi, timer and debug share one synchroniser
  localparam int unsigned SyncBits       = IrqWidth + 4;

  //////////////////////////////////////////////////
  // memory map
  //////////////////////////////////////////////////
  localparam addr_t CtrlBase   = 64'h0000_0000_D000_0000;
  localparam addr_t CtrlLength = 64'h0000_0000_0000_1000;
  localparam addr_t NocBase    = 64'h0000_0000_0D00_1000;
  localparam addr_t NocLength  = 64'h0000_0000_0000_1000;
  localparam data_t DramBase   = 64'h0000_0000_8000_0000;
  localparam data_t DramLength = 64'h0000_0000_4000_0000;
  // read back through DRAM_END
  localparam data_t DramEnd    = DramBase + DramLength;

  // offset bits inside the 4 KiB control window
  localparam int unsigned CtrlOffWidth = 12;

  // control register offsets
  typedef enum logic [CtrlOffWidth-1:0] {
    EXIT          = 12'h000,
    HW_CNT_EN     = 12'h008,
    EVENT_TRIGGER = 12'h010,
    DRAM_BASE     = 12'h018,
    DRAM_END      = 12'h020
  } ctrl_reg_e;

  // noc bridge sender states
  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    DATA
  } noc_state_e;

endpackage

`default_nettype wire

/* list.f */
common/tile_pkg.sv
verilog/tile_sync.sv
periph/ctrl_regs.sv
periph/noc_bridge.sv
periph/periph_response.sv
verilog/tile_top.sv
verification/tb_clock_gen.sv
verification/tb_tile_top.sv

/* periph/ctrl_regs.sv */
//////////////////////////////////////////////////
// control register block
// window decode, read mux and write error
// exit, counter enable and event trigger regs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  wire             clk_i,
  input  wire             reset_l,
  input  wire             req_valid_i,
  input  wire             req_we_i,
  input  tile_pkg::addr_t req_addr_i,
  input  tile_pkg::data_t req_wdata_i,
  output logic            hit_o,
  output tile_pkg::data_t rdata_o,
  output logic            err_o,
  output logic            exit_o,
  output logic            hw_cnt_en_o,
  output tile_pkg::data_t event_trigger_o
);

  import tile_pkg::*;

  ctrl_reg_e offset;
  logic      wr_en;
  logic      exit_q;
  logic      hw_cnt_en_q;
  data_t     event_trigger_q;

  // window decode
  assign hit_o  = (req_addr_i >= CtrlBase) && (req_addr_i < CtrlBase + CtrlLength);
  assign offset = ctrl_reg_e'(req_addr_i[CtrlOffWidth-1:0]);

  //////////////////////////////////////////////////
  // read mux and write check
  //////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    err_o   = 1'b0;
    unique case (offset)
      EXIT: begin
        rdata_o[0] = exit_q;
      end
      HW_CNT_EN: begin
        rdata_o[0] = hw_cnt_en_q;
      end
      EVENT_TRIGGER: begin
        rdata_o = event_trigger_q;
      end
      // dram bounds are read-only
      DRAM_BASE: begin
        rdata_o = DramBase;
        err_o   = req_we_i;
      end
      DRAM_END: begin
        rdata_o = DramEnd;
        err_o   = req_we_i;
      end
      // unlisted offset, reads as zero
      default: begin
        err_o = req_we_i;
      end
    endcase
  end

  // a rejected write leaves every register alone
  assign wr_en = req_valid_i & req_we_i & hit_o & ~err_o;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      exit_q          <= 1'b0;
      hw_cnt_en_q     <= 1'b0;
      event_trigger_q <= '0;
    end else if (wr_en) begin
      // only bit 0 is kept for the flags
      if (offset == EXIT) exit_q <= req_wdata_i[0];
      if (offset == HW_CNT_EN) hw_cnt_en_q <= req_wdata_i[0];
      if (offset == EVENT_TRIGGER) event_trigger_q <= req_wdata_i;
    end
  end

  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = hw_cnt_en_q;
  assign event_trigger_o = event_trigger_q;

endmodule

`default_nettype wire

/* periph/noc_bridge.sv */
//////////////////////////////////////////////////
// NoC window bridge
// captures a write, sends header then data flit
// holds each flit under back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_bridge (
  input  wire             clk_i,
  input  wire             reset_l,
  input  wire             req_valid_i,
  input  wire             req_we_i,
  input  tile_pkg::addr_t req_addr_i,
  input  tile_pkg::data_t req_wdata_i,
  input  wire             noc_ready_i,
  output logic            hit_o,
  output tile_pkg::data_t rdata_o,
  output logic            err_o,
  output logic            noc_valid_o,
  output tile_pkg::flit_t noc_data_o
);

  import tile_pkg::*;

  noc_state_e state_q;
  noc_state_e state_d;
  logic       busy;
  logic       accept;
  logic       flit_done;
  addr_t      addr_q;
  data_t      data_q;

  // window decode
  assign hit_o = (req_addr_i >= NocBase) && (req_addr_i < NocBase + NocLength);

  // pending until the data flit is taken
  assign busy = (state_q != IDLE);

  // writes only get in while idle
  assign err_o  = hit_o & req_we_i & busy;
  assign accept = req_valid_i & req_we_i & hit_o & ~busy;

  // status read, bit 0 is the pending flag
  assign rdata_o = {{(DataWidth-1){1'b0}}, busy};

  //////////////////////////////////////////////////
  // sender FSM
  //////////////////////////////////////////////////

  assign flit_done = noc_valid_o & noc_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:   if (accept) state_d = HEADER;
      HEADER: if (flit_done) state_d = DATA;
      DATA:   if (flit_done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // payload capture, stable until both flits leave
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= req_addr_i;
      data_q <= req_wdata_i;
    end
  end

  // header flit is the address, data flit the write data
  assign noc_valid_o = busy;
  assign noc_data_o  = (state_q == HEADER) ? flit_t'(addr_q) : flit_t'(data_q);

endmodule

`default_nettype wire

/* periph/periph_response.sv */
//////////////////////////////////////////////////
// response combiner
// merges control and NoC results
// one cycle registered response, unmapped error
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module periph_response (
  input  wire             clk_i,
  input  wire             reset_l,
  input  wire             req_valid_i,
  input  wire             req_we_i,
  input  wire             ctrl_hit_i,
  input  tile_pkg::data_t ctrl_rdata_i,
  input  wire             ctrl_err_i,
  input  wire             noc_hit_i,
  input  tile_pkg::data_t noc_rdata_i,
  input  wire             noc_err_i,
  output logic            resp_valid_o,
  output tile_pkg::data_t resp_rdata_o,
  output logic            resp_err_o
);

  import tile_pkg::*;

  data_t sel_rdata;
  logic  sel_err;
  logic  valid_q;
  data_t rdata_q;
  logic  err_q;

  // windows never overlap, so at most one hit
  always_comb begin
    sel_rdata = '0;
    sel_err   = 1'b1;
    if (ctrl_hit_i) begin
      sel_rdata = ctrl_rdata_i;
      sel_err   = ctrl_err_i;
    end else if (noc_hit_i) begin
      sel_rdata = noc_rdata_i;
      sel_err   = noc_err_i;
    end
    // writes return no data
    if (req_we_i) sel_rdata = '0;
  end

  // valid strobe trails the request by one cycle
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  // response payload, only loaded on a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= sel_rdata;
      err_q   <= sel_err;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_rdata_o = rdata_q;
  assign resp_err_o   = err_q;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the tile testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f list.f --top-module tb_tile_top -o sim_tile; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/sim_tile 2>&1); then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

# pass only if the testbench printed its pass line
if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* verification/tb_clock_gen.sv */
//////////////////////////////////////////////////
// testbench clock, 100 ns period
// active-low reset held for 16 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_l_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release on a rising edge
  initial begin
    reset_l_o = 1'b0;
    repeat (16) @(posedge clk_o);
    reset_l_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/tb_tile_top.sv */
//////////////////////////////////////////////////
// tile top testbench
// reference model, compare task, response checker
// reset release, sync, ctrl regs, errors, NoC
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_tile_top;

  import tile_pkg::*;

  // expected response and control levels once the request lands
  typedef struct packed {
    logic  err;
    data_t rdata;
    logic  exit_lvl;
    logic  hw_lvl;
    data_t evt;
    logic  noc_accept;
  } resp_exp_t;

  logic  clk_i;
  logic  reset_l;
  logic  spc_grst_l;
  irq_t  irq_i;
  logic  ipi_i;
  logic  time_irq_i;
  logic  debug_req_i;
  irq_t  irq_o;
  logic  ipi_o;
  logic  time_irq_o;
  logic  debug_req_o;
  logic  req_valid_i;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  resp_valid_o;
  data_t resp_rdata_o;
  logic  resp_err_o;
  logic  exit_o;
  logic  hw_cnt_en_o;
  data_t event_trigger_o;
  logic  noc_valid_o;
  flit_t noc_data_o;
  logic  noc_ready_i;

  integer seed;

  // model state
  logic        m_exit;
  logic        m_hw;
  data_t       m_evt;
  logic        m_noc_pending;
  resp_exp_t   exp_q[$];
  flit_t       flit_q[$];

  // checker history
  logic        prev_req_valid;
  logic        prev_grst;
  logic [4:0]  sync_h1;
  logic [4:0]  sync_h2;
  int unsigned sync_cnt;

  tb_clock_gen i_clock_gen (
    .clk_o     (clk_i),
    .reset_l_o (reset_l)
  );

  tile_top i_dut (
    .clk_i           (clk_i),
    .reset_l         (reset_l),
    .spc_grst_l      (spc_grst_l),
    .irq_i           (irq_i),
    .ipi_i           (ipi_i),
    .time_irq_i      (time_irq_i),
    .debug_req_i     (debug_req_i),
    .irq_o           (irq_o),
    .ipi_o           (ipi_o),
    .time_irq_o      (time_irq_o),
    .debug_req_o     (debug_req_o),
    .req_valid_i     (req_valid_i),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .resp_valid_o    (resp_valid_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_err_o      (resp_err_o),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o),
    .noc_valid_o     (noc_valid_o),
    .noc_data_o      (noc_data_o),
    .noc_ready_i     (noc_ready_i)
  );

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic resp_exp_t model_resp(input logic we, input addr_t addr,
                                           input data_t wdata);
    resp_exp_t   r;
    logic [11:0] off;
    r          = '0;
    // unmapped unless a window hits
    r.err      = 1'b1;
    r.exit_lvl = m_exit;
    r.hw_lvl   = m_hw;
    r.evt      = m_evt;
    off        = addr[11:0];
    if (addr >= CtrlBase && addr < CtrlBase + CtrlLength) begin
      r.err = 1'b0;
      case (off)
        EXIT: begin
          if (we) r.exit_lvl = wdata[0];
          r.rdata = {63'd0, m_exit};
        end
        HW_CNT_EN: begin
          if (we) r.hw_lvl = wdata[0];
          r.rdata = {63'd0, m_hw};
        end
        EVENT_TRIGGER: begin
          if (we) r.evt = wdata;
          r.rdata = m_evt;
        end
        // dram bounds are read-only
        DRAM_BASE: begin
          r.err   = we;
          r.rdata = 64'h0000_0000_8000_0000;
        end
        DRAM_END: begin
          r.err   = we;
          r.rdata = 64'h0000_0000_C000_0000;
        end
        default: begin
          r.err = we;
        end
      endcase
    end else if (addr >= NocBase && addr < NocBase + NocLength) begin
      // busy while flits are pending
      r.err        = we & m_noc_pending;
      r.noc_accept = we & ~m_noc_pending;
      r.rdata      = {63'd0, m_noc_pending};
    end
    if (we) r.rdata = '0;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic data_t rand64();
    data_t v;
    v = {$random(seed), $random(seed)};
    return v;
  endfunction

  // listed offsets plus a few unknown ones just past them
  function automatic addr_t pick_ctrl_addr();
    logic [31:0] rnd;
    rnd = $random(seed);
    return CtrlBase + {58'd0, rnd[2:0], 3'b000};
  endfunction

  // one-cycle strobe
  task automatic drive_req(input logic we, input addr_t addr, input data_t wdata);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // update the model before driving the strobe
  task automatic issue_req(input logic we, input addr_t addr, input data_t wdata);
    resp_exp_t r;
    r      = model_resp(we, addr, wdata);
    m_exit = r.exit_lvl;
    m_hw   = r.hw_lvl;
    m_evt  = r.evt;
    if (r.noc_accept) begin
      m_noc_pending = 1'b1;
      flit_q.push_back(addr);
      flit_q.push_back(wdata);
    end
    exp_q.push_back(r);
    drive_req(we, addr, wdata);
  endtask

  // random back-pressure until both flits are gone
  task automatic drain_noc();
    logic [31:0] rnd;
    int unsigned n;
    n = 0;
    while (flit_q.size() != 0 && n < 500) begin
      @(posedge clk_i);
      rnd = $random(seed);
      noc_ready_i <= rnd[0];
      n++;
    end
    if (flit_q.size() != 0) report_failure("NoC flits were not taken within 500 cycles");
    noc_ready_i   <= 1'b0;
    m_noc_pending = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // checker sampling on the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : check_proc
    resp_exp_t e;
    logic      exp_valid;
    if (reset_l) begin
      // response only for a request seen with the tile out of reset
      exp_valid = prev_req_valid & prev_grst;
      compare_val("resp_valid_o", 64'(resp_valid_o), 64'(exp_valid));
      if (resp_valid_o) begin
        if (exp_q.size() == 0) begin
          report_failure("response arrived with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          compare_val("resp_rdata_o", resp_rdata_o, e.rdata);
          compare_val("resp_err_o", 64'(resp_err_o), 64'(e.err));
          compare_val("exit_o", 64'(exit_o), 64'(e.exit_lvl));
          compare_val("hw_cnt_en_o", 64'(hw_cnt_en_o), 64'(e.hw_lvl));
          compare_val("event_trigger_o", event_trigger_o, e.evt);
        end
      end
      // synchronised inputs trail by two cycles
      if (sync_cnt >= 2) begin
        compare_val("sync outputs", 64'({irq_o, ipi_o, time_irq_o, debug_req_o}),
                    64'(sync_h2));
      end
      sync_h2 = sync_h1;
      sync_h1 = {irq_i, ipi_i, time_irq_i, debug_req_i};
      if (sync_cnt < 2) sync_cnt++;
      // noc flits come in order and hold until taken
      if (noc_valid_o) begin
        if (flit_q.size() == 0) begin
          report_failure("NoC flit sent with nothing pending");
        end else begin
          compare_val("noc_data_o", noc_data_o, flit_q[0]);
          if (noc_ready_i) begin
            void'(flit_q.pop_front());
          end
        end
      end
    end
    prev_req_valid = req_valid_i;
    prev_grst      = spc_grst_l;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    time         t0;
    int unsigned n;
    logic [31:0] rnd;
    addr_t       addr;
    seed           = 32'ha62d;
    irq_i          = '0;
    ipi_i          = 1'b0;
    time_irq_i     = 1'b0;
    debug_req_i    = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    noc_ready_i    = 1'b0;
    m_exit         = 1'b0;
    m_hw           = 1'b0;
    m_evt          = '0;
    m_noc_pending  = 1'b0;
    prev_req_valid = 1'b0;
    prev_grst      = 1'b0;
    sync_h1        = '0;
    sync_h2        = '0;
    sync_cnt       = 0;

    // reset release
    n = 0;
    while (!reset_l && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (!reset_l) report_failure("reset_l was never released");
    t0 = $time;
    compare_val("spc_grst_l", 64'(spc_grst_l), 64'd0);
    compare_val("resp_valid_o", 64'(resp_valid_o), 64'd0);
    compare_val("noc_valid_o", 64'(noc_valid_o), 64'd0);
    compare_val("exit_o", 64'(exit_o), 64'd0);
    compare_val("hw_cnt_en_o", 64'(hw_cnt_en_o), 64'd0);
    compare_val("event_trigger_o", event_trigger_o, 64'd0);

    // ignored while the tile is still held
    drive_req(1'b1, CtrlBase, 64'd1);
    drive_req(1'b0, CtrlBase + 64'h18, 64'd0);
    drive_req(1'b1, NocBase, rand64());

    while (!spc_grst_l && ($time - t0) / 100 < 64'd40000) begin
      @(negedge clk_i);
    end
    if (!spc_grst_l) report_failure("spc_grst_l did not rise within 40000 cycles");
    if (($time - t0) / 100 < 64'd32768) report_failure("spc_grst_l rose before 32768 cycles");
    compare_val("exit_o", 64'(exit_o), 64'd0);
    compare_val("noc_valid_o", 64'(noc_valid_o), 64'd0);

    // random levels through the synchronisers
    repeat (40) begin
      @(posedge clk_i);
      rnd = $random(seed);
      irq_i       <= rnd[1:0];
      ipi_i       <= rnd[2];
      time_irq_i  <= rnd[3];
      debug_req_i <= rnd[4];
    end
    @(posedge clk_i);
    irq_i       <= '0;
    ipi_i       <= 1'b0;
    time_irq_i  <= 1'b0;
    debug_req_i <= 1'b0;

    // control registers
    issue_req(1'b1, CtrlBase + 64'h00, 64'd1);
    issue_req(1'b1, CtrlBase + 64'h08, 64'd1);
    issue_req(1'b1, CtrlBase + 64'h10, rand64());
    for (int i = 0; i < 5; i++) begin
      issue_req(1'b0, CtrlBase + {58'd0, 3'(i), 3'b000}, 64'd0);
    end
    repeat (40) begin
      rnd = $random(seed);
      issue_req(rnd[3], pick_ctrl_addr(), rand64());
    end

    // error cases leave the model state alone
    issue_req(1'b1, CtrlBase + 64'h18, rand64());
    issue_req(1'b1, CtrlBase + 64'h20, rand64());
    issue_req(1'b1, CtrlBase + 64'h28, rand64());
    issue_req(1'b1, CtrlBase + 64'hFF8, rand64());
    issue_req(1'b0, 64'd0, 64'd0);
    issue_req(1'b1, CtrlBase + CtrlLength, rand64());
    issue_req(1'b0, NocBase - 64'd8, 64'd0);
    issue_req(1'b1, NocBase + NocLength, rand64());
    repeat (10) begin
      rnd = $random(seed);
      issue_req(rnd[0], rand64(), rand64());
    end
    issue_req(1'b0, CtrlBase + 64'h00, 64'd0);
    issue_req(1'b0, CtrlBase + 64'h08, 64'd0);
    issue_req(1'b0, CtrlBase + 64'h10, 64'd0);

    // noc writes with busy window and back-pressure
    repeat (6) begin
      rnd  = $random(seed);
      addr = NocBase + {52'd0, rnd[11:3], 3'b000};
      issue_req(1'b1, addr, rand64());
      @(negedge clk_i);
      compare_val("noc_valid_o", 64'(noc_valid_o), 64'd1);
      issue_req(1'b0, NocBase + {52'd0, rnd[20:12], 3'b000}, 64'd0);
      issue_req(1'b1, addr, rand64());
      drain_noc();
      issue_req(1'b0, NocBase, 64'd0);
    end

    n = 0;
    while (exp_q.size() != 0 && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_failure("expected responses never arrived");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_sync.sv */
//////////////////////////////////////////////////
// tile bring-up
// wake-up counter and gated reset
// two-flop synchronisers for reset and interrupts
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tile_sync (
  input  wire            clk_i,
  input  wire            reset_l,
  input  tile_pkg::irq_t irq_i,
  input  wire            ipi_i,
  input  wire            time_irq_i,
  input  wire            debug_req_i,
  output logic           spc_grst_l,
  output tile_pkg::irq_t irq_o,
  output logic           ipi_o,
  output logic           time_irq_o,
  output logic           debug_req_o
);

  import tile_pkg::*;

  //////////////////////////////////////////////////
  // wake-up counter
  //////////////////////////////////////////////////

  // holds the tile in reset while on-chip memories initialise
  logic [WakeUpCntWidth-1:0] wake_cnt_q;
  logic                      wake_done;
  logic                      rst_gate;

  assign wake_done = wake_cnt_q[WakeUpCntWidth-1];

  // saturates once the top bit is set
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + 1'b1;
    end
  end

  // gated reset, still asynchronous to the tile at this point
  assign rst_gate = wake_done & reset_l;

  //////////////////////////////////////////////////
  // synchronisers
  //////////////////////////////////////////////////

  logic [SyncBits-1:0] sync_in;
  logic [SyncBits-1:0] meta_q;
  logic [SyncBits-1:0] sync_q;

  // bit order: gated reset, irq lines, ipi, timer, debug
  assign sync_in = {rst_gate, irq_i, ipi_i, time_irq_i, debug_req_i};

  // first stage may go metastable, second stage settles
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= sync_in;
      sync_q <= meta_q;
    end
  end

  // outputs trail their inputs by two cycles
  assign spc_grst_l  = sync_q[SyncBits-1];
  assign irq_o       = sync_q[SyncBits-2 -: IrqWidth];
  assign ipi_o       = sync_q[2];
  assign time_irq_o  = sync_q[1];
  assign debug_req_o = sync_q[0];

endmodule

`default_nettype wire

/* verilog/tile_top.sv */
//////////////////////////////////////////////////
// tile top level
// bring-up, control regs, NoC bridge, response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tile_top (
  input  wire             clk_i,
  input  wire             reset_l,
  output logic            spc_grst_l,
  // async interrupt and debug inputs
  input  tile_pkg::irq_t  irq_i,
  input  wire             ipi_i,
  input  wire             time_irq_i,
  input  wire             debug_req_i,
  output tile_pkg::irq_t  irq_o,
  output logic            ipi_o,
  output logic            time_irq_o,
  output logic            debug_req_o,
  // peripheral request strobe and response
  input  wire             req_valid_i,
  input  wire             req_we_i,
  input  tile_pkg::addr_t req_addr_i,
  input  tile_pkg::data_t req_wdata_i,
  output logic            resp_valid_o,
  output tile_pkg::data_t resp_rdata_o,
  output logic            resp_err_o,
  // control register levels
  output logic            exit_o,
  output logic            hw_cnt_en_o,
  output tile_pkg::data_t event_trigger_o,
  // noc output
  output logic            noc_valid_o,
  output tile_pkg::flit_t noc_data_o,
  input  wire             noc_ready_i
);

  import tile_pkg::*;

  logic  ctrl_hit;
  data_t ctrl_rdata;
  logic  ctrl_err;
  logic  noc_hit;
  data_t noc_rdata;
  logic  noc_err;

  //////////////////////////////////////////////////
  // bring-up
  //////////////////////////////////////////////////

  tile_sync i_tile_sync (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .irq_i       (irq_i),
    .ipi_i       (ipi_i),
    .time_irq_i  (time_irq_i),
    .debug_req_i (debug_req_i),
    .spc_grst_l  (spc_grst_l),
    .irq_o       (irq_o),
    .ipi_o       (ipi_o),
    .time_irq_o  (time_irq_o),
    .debug_req_o (debug_req_o)
  );

  //////////////////////////////////////////////////
  // peripherals, both run off the gated reset
  //////////////////////////////////////////////////

  ctrl_regs i_ctrl_regs (
    .clk_i           (clk_i),
    .reset_l         (spc_grst_l),
    .req_valid_i     (req_valid_i),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .hit_o           (ctrl_hit),
    .rdata_o         (ctrl_rdata),
    .err_o           (ctrl_err),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o)
  );

  noc_bridge i_noc_bridge (
    .clk_i       (clk_i),
    .reset_l     (spc_grst_l),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .noc_ready_i (noc_ready_i),
    .hit_o       (noc_hit),
    .rdata_o     (noc_rdata),
    .err_o       (noc_err),
    .noc_valid_o (noc_valid_o),
    .noc_data_o  (noc_data_o)
  );

  periph_response i_periph_response (
    .clk_i        (clk_i),
    .reset_l      (spc_grst_l),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .ctrl_hit_i   (ctrl_hit),
    .ctrl_rdata_i (ctrl_rdata),
    .ctrl_err_i   (ctrl_err),
    .noc_hit_i    (noc_hit),
    .noc_rdata_i  (noc_rdata),
    .noc_err_i    (noc_err),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o)
  );

endmodule

`default_nettype wire
